// ==== src/fp_format_pkg.sv ====
`default_nettype none

package fp_format_pkg;

    // operand word width, a half precision value sits in the low bits
    localparam int unsigned XLEN = 32;

    typedef enum logic [1:0] {
        FP32 = 2'd0,
        FP16 = 2'd1
    } fp_format_e;

    // ------------------------------------------------------------------------
    // field widths per format
    // ------------------------------------------------------------------------
    function automatic int unsigned exp_bits(fp_format_e fmt);
        case (fmt)
            FP16:    return 5;
            default: return 8;
        endcase
    endfunction

    function automatic int unsigned man_bits(fp_format_e fmt);
        case (fmt)
            FP16:    return 10;
            default: return 23;
        endcase
    endfunction

    // one record per operand, filled by the classifier
    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        logic is_signalling;
        logic is_quiet;
        logic is_boxed;
    } fp_info_t;

endpackage

`default_nettype wire

// ==== src/fp_status_pkg.sv ====
`default_nettype none

package fp_status_pkg;

    // encoding follows the RISC-V frm field
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } roundmode_e;

    // ------------------------------------------------------------------------
    // accrued exception flags, same bit order as fflags
    // ------------------------------------------------------------------------
    typedef struct packed {
        // invalid operation
        logic NV;
        // divide by zero, never raised by the adder
        logic DZ;
        // overflow
        logic OF;
        // underflow
        logic UF;
        // inexact
        logic NX;
    } fflags_t;

endpackage

`default_nettype wire

// ==== src/fp_classifier.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_classifier import fp_format_pkg::*; #(
    parameter fp_format_e fp_fmt = FP32
) (
    input  logic     [1:0][XLEN-1:0] operands,
    output fp_info_t [1:0]           info
);

    localparam int unsigned exp_w = exp_bits(fp_fmt);
    localparam int unsigned man_w = man_bits(fp_fmt);
    localparam int unsigned fp_w  = 1 + exp_w + man_w;

    for (genvar i = 0; i < 2; i++) begin : g_operand
        logic [exp_w-1:0] exp_field;
        logic [man_w-1:0] man_field;
        logic             exp_zero;
        logic             exp_ones;
        logic             man_zero;

        assign exp_field = operands[i][fp_w-2:man_w];
        assign man_field = operands[i][man_w-1:0];

        assign exp_zero = (exp_field == '0);
        assign exp_ones = &exp_field;
        assign man_zero = (man_field == '0);

        assign info[i].is_zero      = exp_zero & man_zero;
        assign info[i].is_subnormal = exp_zero & ~man_zero;
        assign info[i].is_normal    = ~exp_zero & ~exp_ones;
        assign info[i].is_inf       = exp_ones & man_zero;
        assign info[i].is_nan       = exp_ones & ~man_zero;

        // quiet bit is the top mantissa bit
        assign info[i].is_signalling = exp_ones & ~man_zero & ~man_field[man_w-1];
        assign info[i].is_quiet      = exp_ones & man_field[man_w-1];

        // bits above the format must be clear
        assign info[i].is_boxed = ((operands[i] >> fp_w) == '0);
    end

endmodule

`default_nettype wire

// ==== src/lzc.sv ====
`timescale 1ns/10ps
`default_nettype none

// mode 1 counts leading zeros, mode 0 trailing zeros
module lzc #(
    parameter  int unsigned width    = 8,
    parameter  bit          mode     = 1'b1,
    localparam int unsigned cnt_bits = (width > 1) ? $clog2(width) : 1
) (
    input  logic [width-1:0]    in_bits,
    output logic [cnt_bits-1:0] count,
    output logic                empty
);

    localparam int unsigned padded = 2 ** cnt_bits;

    // binary heap, node n has children 2n+1 (searched first) and 2n+2
    logic [2*padded-2:0] node_valid;
    logic [cnt_bits-1:0] node_cnt [2*padded-1];

    for (genvar j = 0; j < padded; j++) begin : g_leaf
        if (j < width) begin : g_bit
            assign node_valid[padded-1+j] = mode ? in_bits[width-1-j] : in_bits[j];
        end else begin : g_pad
            assign node_valid[padded-1+j] = 1'b0;
        end
        assign node_cnt[padded-1+j] = '0;
    end

    // each stage prefers the first half and adds the half size otherwise
    for (genvar k = 0; k < cnt_bits; k++) begin : g_level
        for (genvar j = 0; j < 2 ** k; j++) begin : g_node
            localparam int unsigned node = 2 ** k - 1 + j;

            assign node_valid[node] = node_valid[2*node+1] | node_valid[2*node+2];
            assign node_cnt[node]   = node_valid[2*node+1] ? node_cnt[2*node+1] :
                                      node_cnt[2*node+2] | (cnt_bits'(1) << (cnt_bits - 1 - k));
        end
    end

    assign count = node_cnt[0];
    assign empty = ~node_valid[0];

endmodule

`default_nettype wire

// ==== src/fp_rounding.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_rounding import fp_status_pkg::*; #(
    parameter int unsigned man_width = 23
) (
    input  logic [man_width-1:0] mant_in,
    input  logic                 guard,
    input  logic                 sticky,
    input  logic                 sign,
    input  roundmode_e           round_mode,
    output logic [man_width-1:0] mant_out,
    output logic                 inexact,
    output logic                 carry_out,
    output logic                 rounded_up
);

    logic round_inc;

    // ------------------------------------------------------------------------
    // increment decision
    // ------------------------------------------------------------------------
    always_comb begin
        case (round_mode)
            // ties go to the even neighbour
            RNE:     round_inc = guard & (sticky | mant_in[0]);
            RTZ:     round_inc = 1'b0;
            RDN:     round_inc = (guard | sticky) & sign;
            RUP:     round_inc = (guard | sticky) & ~sign;
            // ties away from zero
            RMM:     round_inc = guard;
            default: round_inc = 1'b0;
        endcase
    end

    assign {carry_out, mant_out} = {1'b0, mant_in} + {{man_width{1'b0}}, round_inc};

    assign inexact    = guard | sticky;
    assign rounded_up = round_inc;

    // an exact tie under round to nearest even lands on an even mantissa
    always_comb begin
        a_tie_even: assert final (!(round_mode == RNE && guard && !sticky) || !mant_out[0])
            else $error("rounding tie left an odd mantissa %h", mant_out);
    end

endmodule

`default_nettype wire

// ==== src/fp_adder_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_adder_core import fp_format_pkg::*, fp_status_pkg::*; #(
    parameter fp_format_e fp_fmt = FP32
) (
    input  logic            clk,
    input  logic            reset,
    input  roundmode_e      round_mode,
    input  logic            sub,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  fp_info_t        info_a,
    input  fp_info_t        info_b,
    output logic [XLEN-1:0] res,
    output fflags_t         status
);

    localparam int unsigned exp_w = exp_bits(fp_fmt);
    localparam int unsigned man_w = man_bits(fp_fmt);
    // hidden bit, mantissa, guard bit and round bit
    localparam int unsigned ext_w = man_w + 3;
    localparam int unsigned lz_w  = $clog2(ext_w);

    typedef struct packed {
        logic             sign;
        logic [exp_w-1:0] exp;
        logic [man_w-1:0] mant;
    } fp_t;

    fp_t fp_a, fp_b_in, fp_b;

    assign fp_a    = rs1_data[$bits(fp_t)-1:0];
    assign fp_b_in = rs2_data[$bits(fp_t)-1:0];
    assign fp_b    = '{sign: fp_b_in.sign ^ sub, exp: fp_b_in.exp, mant: fp_b_in.mant};

    // ------------------------------------------------------------------------
    // alignment
    // ------------------------------------------------------------------------
    logic             exp_nz_a, exp_nz_b;
    logic [exp_w-1:0] raw_exp_a, raw_exp_b;
    logic [ext_w-1:0] ext_mant_a, ext_mant_b;

    assign exp_nz_a = |fp_a.exp;
    assign exp_nz_b = |fp_b.exp;
    // subnormals share the scale of exponent 1
    assign raw_exp_a  = exp_nz_a ? fp_a.exp : exp_w'(1);
    assign raw_exp_b  = exp_nz_b ? fp_b.exp : exp_w'(1);
    assign ext_mant_a = {exp_nz_a, fp_a.mant, 2'b00};
    assign ext_mant_b = {exp_nz_b, fp_b.mant, 2'b00};

    logic             swap, eff_sub, sticky;
    logic             sign_big, sign_small;
    logic [exp_w-1:0] big_exp, exp_diff;
    logic [ext_w-1:0] mant_big, mant_small_raw, mant_small;

    assign swap           = raw_exp_b > raw_exp_a;
    assign big_exp        = swap ? raw_exp_b : raw_exp_a;
    assign exp_diff       = swap ? raw_exp_b - raw_exp_a : raw_exp_a - raw_exp_b;
    assign mant_big       = swap ? ext_mant_b : ext_mant_a;
    assign mant_small_raw = swap ? ext_mant_a : ext_mant_b;
    assign sign_big       = swap ? fp_b.sign : fp_a.sign;
    assign sign_small     = swap ? fp_a.sign : fp_b.sign;
    assign mant_small     = mant_small_raw >> exp_diff;
    // any bit lost in the shift leaves a fraction below the round bit
    assign sticky         = (mant_small << exp_diff) != mant_small_raw;
    assign eff_sub        = fp_a.sign ^ fp_b.sign;

    // ------------------------------------------------------------------------
    // magnitude add
    // ------------------------------------------------------------------------
    logic [ext_w:0] sum_d;
    logic           sign_d;

    always_comb begin
        sum_d  = {1'b0, mant_big} + {1'b0, mant_small};
        sign_d = sign_big;
        if (eff_sub) begin
            // small can only win with equal exponents, then nothing was shifted out
            if (mant_small > mant_big) begin
                sum_d  = {1'b0, mant_small} - {1'b0, mant_big};
                sign_d = sign_small;
            end else begin
                // the sticky fraction borrows one unit from the round bit
                sum_d = {1'b0, mant_big} - {1'b0, mant_small} - {{ext_w{1'b0}}, sticky};
                if (mant_big == mant_small && !sticky) begin
                    sign_d = (round_mode == RDN);
                end
            end
        end
    end

    // special cases, decided alongside the add
    fp_t     special_res;
    fflags_t special_flags;
    logic    is_special;
    logic    nan_a, nan_b;

    // an operand with stray upper bits counts as a NaN
    assign nan_a = info_a.is_nan | ~info_a.is_boxed;
    assign nan_b = info_b.is_nan | ~info_b.is_boxed;

    always_comb begin
        special_res   = '{sign: 1'b0, exp: '1, mant: {1'b1, {(man_w-1){1'b0}}}};
        special_flags = '0;
        is_special    = 1'b0;
        if (nan_a | nan_b) begin
            is_special       = 1'b1;
            special_flags.NV = info_a.is_signalling | info_b.is_signalling;
        end else if (info_a.is_inf | info_b.is_inf) begin
            is_special = 1'b1;
            if (info_a.is_inf & info_b.is_inf & eff_sub) begin
                special_flags.NV = 1'b1;
            end else if (info_a.is_inf) begin
                special_res = '{sign: fp_a.sign, exp: '1, mant: '0};
            end else begin
                special_res = '{sign: fp_b.sign, exp: '1, mant: '0};
            end
        end
    end

    logic [ext_w:0]   sum_q;
    logic [exp_w-1:0] exp_q;
    logic             sticky_q, sign_q, special_q;
    roundmode_e       rm_q;
    fp_t              special_res_q;
    fflags_t          special_flags_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_q           <= '0;
            exp_q           <= '0;
            sticky_q        <= 1'b0;
            sign_q          <= 1'b0;
            rm_q            <= RNE;
            special_q       <= 1'b0;
            special_res_q   <= '0;
            special_flags_q <= '0;
        end else begin
            sum_q           <= sum_d;
            exp_q           <= big_exp;
            sticky_q        <= sticky;
            sign_q          <= sign_d;
            rm_q            <= round_mode;
            special_q       <= is_special;
            special_res_q   <= special_res;
            special_flags_q <= special_flags;
        end
    end

    // ------------------------------------------------------------------------
    // normalisation
    // ------------------------------------------------------------------------
    logic [lz_w-1:0]  lz_count;
    logic             lz_empty;
    logic [exp_w-1:0] shift_limit, norm_shamt;
    logic [exp_w:0]   align_exp;
    logic [ext_w-1:0] norm_mant;
    logic             norm_sticky;

    lzc #(
        .width (ext_w),
        .mode  (1'b1)
    ) i_lzc (
        .in_bits (sum_q[ext_w-1:0]),
        .count   (lz_count),
        .empty   (lz_empty)
    );

    // never shift below exponent 1, the rest stays subnormal
    assign shift_limit = exp_q - 1'b1;
    assign norm_shamt  = (exp_w'(lz_count) > shift_limit) ? shift_limit : exp_w'(lz_count);

    always_comb begin
        align_exp   = {1'b0, exp_q};
        norm_mant   = sum_q[ext_w-1:0];
        norm_sticky = sticky_q;
        if (sum_q[ext_w]) begin
            align_exp   = {1'b0, exp_q} + 1'b1;
            norm_mant   = sum_q[ext_w:1];
            norm_sticky = sum_q[0] | sticky_q;
        end else if (!lz_empty) begin
            align_exp = {1'b0, exp_q} - {1'b0, norm_shamt};
            norm_mant = sum_q[ext_w-1:0] << norm_shamt;
        end
    end

    // ------------------------------------------------------------------------
    // rounding and overflow
    // ------------------------------------------------------------------------
    logic [man_w-1:0] round_mant;
    logic             round_ix, round_cout;
    logic [exp_w:0]   enc_exp, final_exp;
    logic             overflow, to_inf;
    fp_t              normal_res;
    fflags_t          normal_flags;

    fp_rounding #(
        .man_width (man_w)
    ) i_rounding (
        .mant_in    (norm_mant[ext_w-2:2]),
        .guard      (norm_mant[1]),
        .sticky     (norm_mant[0] | norm_sticky),
        .sign       (sign_q),
        .round_mode (rm_q),
        .mant_out   (round_mant),
        .inexact    (round_ix),
        .carry_out  (round_cout),
        .rounded_up ()
    );

    // no hidden bit means a subnormal, encoded with exponent 0
    assign enc_exp   = norm_mant[ext_w-1] ? align_exp : '0;
    assign final_exp = enc_exp + round_cout;
    assign overflow  = final_exp >= {1'b0, {exp_w{1'b1}}};

    always_comb begin
        case (rm_q)
            RTZ:     to_inf = 1'b0;
            RDN:     to_inf = sign_q;
            RUP:     to_inf = ~sign_q;
            default: to_inf = 1'b1;
        endcase
    end

    always_comb begin
        normal_res = '{sign: sign_q, exp: final_exp[exp_w-1:0], mant: round_mant};
        if (overflow) begin
            normal_res.exp  = to_inf ? {exp_w{1'b1}} : {{(exp_w-1){1'b1}}, 1'b0};
            normal_res.mant = {man_w{~to_inf}};
        end
        normal_flags    = '0;
        normal_flags.OF = overflow;
        normal_flags.NX = round_ix | overflow;
        normal_flags.UF = round_ix & (final_exp == '0);
    end

    assign res    = special_q ? XLEN'(special_res_q) : XLEN'(normal_res);
    assign status = special_q ? special_flags_q : normal_flags;

    // the output stage settles to known values once out of reset
    a_no_x_out: assert property (@(posedge clk) disable iff (reset) !$isunknown({res, status}))
        else $error("unknown bits on res %h or status %h", res, status);

endmodule

`default_nettype wire

// ==== src/fp_add_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_add_unit import fp_format_pkg::*, fp_status_pkg::*; #(
    parameter fp_format_e fp_fmt = FP32
) (
    input  logic            clk,
    input  logic            reset,
    input  roundmode_e      round_mode,
    input  logic            sub,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic [XLEN-1:0] res,
    output fflags_t         status
);

    // index 0 describes rs1, index 1 describes rs2
    fp_info_t [1:0] info;

    fp_classifier #(
        .fp_fmt (fp_fmt)
    ) i_classifier (
        .operands ({rs2_data, rs1_data}),
        .info     (info)
    );

    fp_adder_core #(
        .fp_fmt (fp_fmt)
    ) i_adder_core (
        .clk        (clk),
        .reset      (reset),
        .round_mode (round_mode),
        .sub        (sub),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .info_a     (info[0]),
        .info_b     (info[1]),
        .res        (res),
        .status     (status)
    );

endmodule

`default_nettype wire

// ==== tb/fp_add_model.svh ====
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// ----------------------------------------------------------------------------
// single precision reference for add and subtract
// every finite operand becomes an exact integer in units of 2^-149, so the
// sum is exact and rounding happens once on the wide value
// ----------------------------------------------------------------------------
localparam int WIDE = 300;

task automatic reference_add(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic            sub_op,
    input  roundmode_e      rm,
    output logic [XLEN-1:0] r,
    output fflags_t         f
);
    logic            sa, sb, sr, inc;
    logic [7:0]      ea, eb;
    logic [22:0]     ma, mb;
    logic            nan_a, nan_b, inf_a, inf_b;
    logic [WIDE-1:0] va, vb, mag, keep, rem, half;
    int              ea_eff, eb_eff, top, sh, ex;

    sa = a[31];
    ea = a[30:23];
    ma = a[22:0];
    // subtraction is addition with the sign of b flipped
    sb = b[31] ^ sub_op;
    eb = b[30:23];
    mb = b[22:0];
    nan_a = (ea == 8'hff) && (ma != 23'h0);
    nan_b = (eb == 8'hff) && (mb != 23'h0);
    inf_a = (ea == 8'hff) && (ma == 23'h0);
    inf_b = (eb == 8'hff) && (mb == 23'h0);
    f = '0;
    r = '0;

    if (nan_a || nan_b) begin
        r    = 32'h7fc0_0000;
        f.NV = (nan_a && !ma[22]) || (nan_b && !mb[22]);
    end else if (inf_a && inf_b && (sa != sb)) begin
        r    = 32'h7fc0_0000;
        f.NV = 1'b1;
    end else if (inf_a) begin
        r = {sa, 8'hff, 23'h0};
    end else if (inf_b) begin
        r = {sb, 8'hff, 23'h0};
    end else begin
        // a subnormal has the scale of exponent 1 and no hidden bit
        ea_eff = (ea == 8'h00) ? 1 : int'(ea);
        eb_eff = (eb == 8'h00) ? 1 : int'(eb);
        va = WIDE'({(ea != 8'h00), ma}) << (ea_eff - 1);
        vb = WIDE'({(eb != 8'h00), mb}) << (eb_eff - 1);
        if (sa == sb) begin
            mag = va + vb;
            sr  = sa;
        end else if (va >= vb) begin
            mag = va - vb;
            sr  = sa;
        end else begin
            mag = vb - va;
            sr  = sb;
        end

        if (mag == '0) begin
            if (sa != sb) begin
                sr = (rm == RDN);
            end
            r = {sr, 31'h0};
        end else begin
            top = 0;
            for (int i = 0; i < WIDE; i++) begin
                if (mag[i]) begin
                    top = i;
                end
            end
            if (top < 23) begin
                // below the normal range the sum fits exactly
                r = {sr, 8'h00, mag[22:0]};
            end else begin
                sh   = top - 23;
                ex   = top - 22;
                keep = mag >> sh;
                rem  = mag - (keep << sh);
                half = (sh == 0) ? '0 : (WIDE'(1) << (sh - 1));
                case (rm)
                    RNE:     inc = (rem > half) || ((rem == half) && (rem != '0) && keep[0]);
                    RTZ:     inc = 1'b0;
                    RDN:     inc = (rem != '0) && sr;
                    RUP:     inc = (rem != '0) && !sr;
                    default: inc = (rem != '0) && (rem >= half);
                endcase
                keep = keep + WIDE'(inc);
                if (keep[24]) begin
                    keep = keep >> 1;
                    ex   = ex + 1;
                end
                f.NX = (rem != '0);
                if (ex >= 255) begin
                    f.OF = 1'b1;
                    f.NX = 1'b1;
                    // modes rounding toward zero stop at the largest finite value
                    if (rm == RTZ || (rm == RDN && !sr) || (rm == RUP && sr)) begin
                        r = {sr, 8'hfe, 23'h7f_ffff};
                    end else begin
                        r = {sr, 8'hff, 23'h0};
                    end
                end else begin
                    r = {sr, ex[7:0], keep[22:0]};
                end
                f.UF = f.NX && (r[30:23] == 8'h00);
            end
        end
    end
endtask

`endif

// ==== tb/tb_fp_add.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fp_add
    import fp_format_pkg::*, fp_status_pkg::*;
();

    localparam int num_vectors  = 6000;
    localparam int reset_cycles = 3;
    localparam int cycle_limit  = num_vectors + reset_cycles + 20;

    logic            clk = 1'b0;
    logic            reset;
    logic            sub;
    roundmode_e      round_mode;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] res;
    fflags_t         status;

    logic [31:0] rng_state;
    int          res_errors  = 0;
    int          flag_errors = 0;
    int          cycle_count = 0;

    `include "fp_add_model.svh"

    fp_add_unit #(
        .fp_fmt (FP32)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .round_mode (round_mode),
        .sub        (sub),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .res        (res),
        .status     (status)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------------
    // random source
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // three in four draws are plain words, the rest lean toward hard cases
    function automatic logic [31:0] pick_operand(input logic [31:0] other);
        logic [31:0] r;
        logic [31:0] k;
        r = next_random();
        if (r[1:0] != 2'b00) begin
            return next_random();
        end
        k = next_random();
        case (k[2:0])
            3'd0:    return {k[31], 31'h0};
            3'd1:    return {k[31], 8'hff, 23'h0};
            3'd2:    return {k[31], 8'hff, 1'b1, k[21:0]};
            3'd3:    return {k[31], 8'hff, 1'b0, k[21:1], 1'b1};
            3'd4:    return {k[31], 8'h00, k[22:0]};
            3'd5:    return {k[31], other[30:23], k[22:0]};
            // near copy of the other operand, cancels under subtraction
            3'd6:    return {k[31], other[30:4], k[3:0]};
            default: return {k[31], 8'hfe, k[22:0]};
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_res(
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b,
        input logic [XLEN-1:0] expected,
        input logic [XLEN-1:0] actual
    );
        if (actual !== expected) begin
            res_errors++;
            $display("CHECK FAILED res: expected %h, got %h (rs1 %h, rs2 %h, t=%0t)",
                     expected, actual, a, b, $time);
        end
    endtask

    task automatic check_flags(input fflags_t expected, input fflags_t actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("CHECK FAILED status: expected %h, got %h (t=%0t)",
                     expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [XLEN-1:0] a, b, exp_res;
        logic [31:0]     rnd;
        fflags_t         exp_flags;
        roundmode_e      rm;

        rng_state  = 32'h6c8f_4146;
        reset      = 1'b1;
        sub        = 1'b0;
        round_mode = RNE;
        // live operands during reset must not reach the output
        rs1_data   = 32'h3f80_0000;
        rs2_data   = 32'h4000_0000;

        repeat (reset_cycles) begin
            @(negedge clk);
            check_res(rs1_data, rs2_data, '0, res);
            check_flags('0, status);
        end
        // output stays cleared until the next rising edge
        reset = 1'b0;

        // a new operation every cycle, its expected values held one cycle
        for (int i = 0; i < num_vectors; i++) begin
            a   = pick_operand(next_random());
            b   = pick_operand(a);
            rnd = next_random();
            rm  = roundmode_e'(3'(rnd % 32'd5));
            sub        = rnd[8];
            round_mode = rm;
            rs1_data   = a;
            rs2_data   = b;
            reference_add(a, b, rnd[8], rm, exp_res, exp_flags);
            @(negedge clk);
            check_res(a, b, exp_res, res);
            check_flags(exp_flags, status);
        end

        $display("errors: %0d (res %0d, status %0d)",
                 res_errors + flag_errors, res_errors, flag_errors);
        if (res_errors + flag_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tb
src/fp_format_pkg.sv
src/fp_status_pkg.sv
src/fp_classifier.sv
src/lzc.sv
src/fp_rounding.sv
src/fp_adder_core.sv
src/fp_add_unit.sv
tb/tb_fp_add.sv

// ==== Bender.yml ====
package:
  name: fp_add

sources:
  # packages first, then leaf modules, then the top level
  - src/fp_format_pkg.sv
  - src/fp_status_pkg.sv
  - src/fp_classifier.sv
  - src/lzc.sv
  - src/fp_rounding.sv
  - src/fp_adder_core.sv
  - src/fp_add_unit.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_fp_add.sv
